// File: Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_pkg.sv
  - logic/rv_pipe_reg.sv
  - logic/rv_decoder.sv
  - logic/rv_regfile.sv
  - logic/rv_alu.sv
  - logic/rv_hazard_unit.sv
  - logic/rv_core.sv
  - target: test
    files:
      - tests/rv_core_tb.sv

// File: logic/rv_alu.sv
// Execute stage ALU and branch unit
`timescale 1ns/100ps

module rv_alu (
	input  rv_pkg::word_t i_a,
	input  rv_pkg::word_t i_b,
	input  rv_pkg::word_t i_rs1_val,
	input  rv_pkg::word_t i_rs2_val,
	input  rv_pkg::word_t i_pc,
	input  rv_pkg::word_t i_imm,
	input  rv_pkg::ctrl_t i_ctrl,
	output rv_pkg::word_t o_result,
	output logic          o_redirect,
	output rv_pkg::word_t o_target
);

	rv_pkg::word_t alu_val;
	logic          eq;
	logic          lt;
	logic          taken;

	always_comb
	begin
		case (i_ctrl.alu_op)
			rv_pkg::ALU_ADD:    alu_val = i_a + i_b;
			rv_pkg::ALU_SUB:    alu_val = i_a - i_b;
			rv_pkg::ALU_AND:    alu_val = i_a & i_b;
			rv_pkg::ALU_OR:     alu_val = i_a | i_b;
			rv_pkg::ALU_XOR:    alu_val = i_a ^ i_b;
			rv_pkg::ALU_SLT:    alu_val = rv_pkg::word_t'($signed(i_a) < $signed(i_b));
			rv_pkg::ALU_SLL:    alu_val = i_a << i_b[rv_pkg::SHAMT_W-1:0];
			rv_pkg::ALU_SRL:    alu_val = i_a >> i_b[rv_pkg::SHAMT_W-1:0];
			rv_pkg::ALU_PASS_B: alu_val = i_b;
			default:            alu_val = '0;
		endcase
	end

	// Signed compare on forwarded register values
	assign eq = (i_rs1_val == i_rs2_val);
	assign lt = ($signed(i_rs1_val) < $signed(i_rs2_val));

	always_comb
	begin
		case (i_ctrl.branch_kind)
			rv_pkg::BR_BEQ: taken = eq;
			rv_pkg::BR_BNE: taken = !eq;
			rv_pkg::BR_BLT: taken = lt;
			rv_pkg::BR_BGE: taken = !lt;
			rv_pkg::BR_JAL: taken = 1'b1;
			default:        taken = 1'b0;
		endcase
	end

	// JAL links the return address
	assign o_result   = (i_ctrl.branch_kind == rv_pkg::BR_JAL) ? i_pc + 32'd4 : alu_val;
	assign o_redirect = taken;
	assign o_target   = i_pc + i_imm;

endmodule

// File: logic/rv_core.sv
// Five-stage RV32I core
`timescale 1ns/100ps

module rv_core (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_halt,
	output rv_pkg::word_t    o_imem_addr,
	input  rv_pkg::word_t    i_imem_data,
	output rv_pkg::word_t    o_dmem_addr,
	output rv_pkg::word_t    o_dmem_wdata,
	output logic             o_dmem_we,
	output logic             o_dmem_re,
	input  rv_pkg::word_t    i_dmem_rdata,
	output logic             o_wb_valid,
	output rv_pkg::reg_idx_t o_wb_rd,
	output rv_pkg::word_t    o_wb_data
);

	rv_pkg::word_t     pc_q;
	rv_pkg::word_t     pc_next;
	logic              pc_hold;

	rv_pkg::if_id_t    if_id_d;
	rv_pkg::if_id_t    if_id_q;
	rv_pkg::if_id_t    if_id_nop;
	rv_pkg::id_ex_t    id_ex_d;
	rv_pkg::id_ex_t    id_ex_q;
	rv_pkg::id_ex_t    id_ex_nop;
	rv_pkg::ex_mem_t   ex_mem_d;
	rv_pkg::ex_mem_t   ex_mem_q;
	rv_pkg::ex_mem_t   ex_mem_nop;
	rv_pkg::mem_wb_t   mem_wb_d;
	rv_pkg::mem_wb_t   mem_wb_q;
	rv_pkg::mem_wb_t   mem_wb_nop;

	rv_pkg::reg_idx_t  dec_rs1;
	rv_pkg::reg_idx_t  dec_rs2;
	rv_pkg::reg_idx_t  dec_rd;
	rv_pkg::word_t     dec_imm;
	rv_pkg::ctrl_t     dec_ctrl;
	rv_pkg::word_t     rf_rs1_val;
	rv_pkg::word_t     rf_rs2_val;

	rv_pkg::opnd_sel_e sel_a;
	rv_pkg::opnd_sel_e sel_b;
	logic              load_stall;
	rv_pkg::word_t     opnd_a;
	rv_pkg::word_t     opnd_rs2;
	rv_pkg::word_t     alu_b;
	rv_pkg::word_t     ex_result;
	logic              redirect;
	rv_pkg::word_t     target;

	rv_pkg::word_t     wb_data;
	logic              wb_wen;

	// ==================================================
	// Stall and flush control
	// ==================================================
	// Redirect wins over a load-use stall
	assign pc_hold = i_halt || (load_stall && !redirect);
	assign pc_next = redirect ? target : pc_q + 32'd4;

	// Bubble payloads
	assign if_id_nop  = '{pc: rv_pkg::RESET_PC, inst: rv_pkg::NOP_INST};
	assign id_ex_nop  = '0;
	assign ex_mem_nop = '0;
	assign mem_wb_nop = '0;

	// ==================================================
	// Fetch
	// ==================================================
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc_q <= rv_pkg::RESET_PC;
		else if (!pc_hold)
			pc_q <= pc_next;
	end

	assign o_imem_addr = pc_q;
	assign if_id_d     = '{pc: pc_q, inst: i_imem_data};

	rv_pipe_reg #(.payload_t(rv_pkg::if_id_t)) u_if_id (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_hold  (pc_hold),
		.i_flush (redirect),
		.i_d     (if_id_d),
		.i_nop   (if_id_nop),
		.o_q     (if_id_q)
	);

	// ==================================================
	// Decode
	// ==================================================
	rv_decoder u_decoder (
		.i_inst (if_id_q.inst),
		.o_rs1  (dec_rs1),
		.o_rs2  (dec_rs2),
		.o_rd   (dec_rd),
		.o_imm  (dec_imm),
		.o_ctrl (dec_ctrl)
	);

	rv_regfile u_regfile (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_rs1     (dec_rs1),
		.i_rs2     (dec_rs2),
		.i_wen     (wb_wen),
		.i_rd      (mem_wb_q.rd),
		.i_wdata   (wb_data),
		.o_rs1_val (rf_rs1_val),
		.o_rs2_val (rf_rs2_val)
	);

	always_comb
	begin
		id_ex_d.pc      = if_id_q.pc;
		id_ex_d.rs1     = dec_rs1;
		id_ex_d.rs2     = dec_rs2;
		id_ex_d.rd      = dec_rd;
		id_ex_d.rs1_val = rf_rs1_val;
		id_ex_d.rs2_val = rf_rs2_val;
		id_ex_d.imm     = dec_imm;
		id_ex_d.ctrl    = dec_ctrl;
	end

	rv_pipe_reg #(.payload_t(rv_pkg::id_ex_t)) u_id_ex (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_hold  (i_halt),
		.i_flush (redirect || load_stall),
		.i_d     (id_ex_d),
		.i_nop   (id_ex_nop),
		.o_q     (id_ex_q)
	);

	// ==================================================
	// Execute
	// ==================================================
	rv_hazard_unit u_hazard (
		.i_rs1_ex     (id_ex_q.rs1),
		.i_rs2_ex     (id_ex_q.rs2),
		.i_rd_mem     (ex_mem_q.rd),
		.i_wen_mem    (ex_mem_q.reg_wen),
		.i_rd_wb      (mem_wb_q.rd),
		.i_wen_wb     (mem_wb_q.reg_wen),
		.i_rs1_id     (dec_rs1),
		.i_rs2_id     (dec_rs2),
		.i_rd_ex      (id_ex_q.rd),
		.i_load_ex    (id_ex_q.ctrl.mem_read),
		.o_sel_a      (sel_a),
		.o_sel_b      (sel_b),
		.o_load_stall (load_stall)
	);

	function automatic rv_pkg::word_t fwd_mux(
		rv_pkg::opnd_sel_e sel,
		rv_pkg::word_t     rf_val,
		rv_pkg::word_t     mem_val,
		rv_pkg::word_t     wb_val
	);
		case (sel)
			rv_pkg::SEL_MEM: return mem_val;
			rv_pkg::SEL_WB:  return wb_val;
			default:         return rf_val;
		endcase
	endfunction

	assign opnd_a   = fwd_mux(sel_a, id_ex_q.rs1_val, ex_mem_q.alu_out, wb_data);
	assign opnd_rs2 = fwd_mux(sel_b, id_ex_q.rs2_val, ex_mem_q.alu_out, wb_data);
	assign alu_b    = id_ex_q.ctrl.use_imm ? id_ex_q.imm : opnd_rs2;

	rv_alu u_alu (
		.i_a        (opnd_a),
		.i_b        (alu_b),
		.i_rs1_val  (opnd_a),
		.i_rs2_val  (opnd_rs2),
		.i_pc       (id_ex_q.pc),
		.i_imm      (id_ex_q.imm),
		.i_ctrl     (id_ex_q.ctrl),
		.o_result   (ex_result),
		.o_redirect (redirect),
		.o_target   (target)
	);

	always_comb
	begin
		ex_mem_d.rd          = id_ex_q.rd;
		ex_mem_d.alu_out     = ex_result;
		// Store data comes from the forwarded rs2
		ex_mem_d.store_data  = opnd_rs2;
		ex_mem_d.mem_read    = id_ex_q.ctrl.mem_read;
		ex_mem_d.mem_write   = id_ex_q.ctrl.mem_write;
		ex_mem_d.reg_wen     = id_ex_q.ctrl.reg_wen;
		ex_mem_d.wb_from_mem = id_ex_q.ctrl.wb_from_mem;
	end

	rv_pipe_reg #(.payload_t(rv_pkg::ex_mem_t)) u_ex_mem (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_hold  (i_halt),
		.i_flush (1'b0),
		.i_d     (ex_mem_d),
		.i_nop   (ex_mem_nop),
		.o_q     (ex_mem_q)
	);

	// ==================================================
	// Memory
	// ==================================================
	assign o_dmem_addr  = ex_mem_q.alu_out;
	assign o_dmem_wdata = ex_mem_q.store_data;
	assign o_dmem_we    = ex_mem_q.mem_write && !i_halt;
	assign o_dmem_re    = ex_mem_q.mem_read && !i_halt;

	always_comb
	begin
		mem_wb_d.rd          = ex_mem_q.rd;
		mem_wb_d.alu_out     = ex_mem_q.alu_out;
		mem_wb_d.mem_data    = i_dmem_rdata;
		mem_wb_d.reg_wen     = ex_mem_q.reg_wen;
		mem_wb_d.wb_from_mem = ex_mem_q.wb_from_mem;
	end

	rv_pipe_reg #(.payload_t(rv_pkg::mem_wb_t)) u_mem_wb (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_hold  (i_halt),
		.i_flush (1'b0),
		.i_d     (mem_wb_d),
		.i_nop   (mem_wb_nop),
		.o_q     (mem_wb_q)
	);

	// ==================================================
	// Write-back and retire
	// ==================================================
	assign wb_data = mem_wb_q.wb_from_mem ? mem_wb_q.mem_data : mem_wb_q.alu_out;
	assign wb_wen  = mem_wb_q.reg_wen && !i_halt;

	// Writes to x0 do not count as retirements
	assign o_wb_valid = wb_wen && (mem_wb_q.rd != '0);
	assign o_wb_rd    = mem_wb_q.rd;
	assign o_wb_data  = wb_data;

endmodule

// File: logic/rv_decoder.sv
// RV32I subset decoder
`timescale 1ns/100ps

module rv_decoder (
	input  rv_pkg::word_t    i_inst,
	output rv_pkg::reg_idx_t o_rs1,
	output rv_pkg::reg_idx_t o_rs2,
	output rv_pkg::reg_idx_t o_rd,
	output rv_pkg::word_t    o_imm,
	output rv_pkg::ctrl_t    o_ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       use_rs1;
	logic       use_rs2;

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];
	assign funct7 = i_inst[31:25];

	// Unused source fields read as x0 so they never match a hazard
	assign o_rs1 = use_rs1 ? i_inst[19:15] : '0;
	assign o_rs2 = use_rs2 ? i_inst[24:20] : '0;
	assign o_rd  = i_inst[11:7];

	always_comb
	begin
		o_ctrl  = '0;
		o_imm   = '0;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (opcode)
			rv_pkg::OPC_OP:
			begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				o_ctrl.reg_wen = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: o_ctrl.alu_op = rv_pkg::ALU_ADD;
					{7'b0100000, 3'b000}: o_ctrl.alu_op = rv_pkg::ALU_SUB;
					{7'b0000000, 3'b001}: o_ctrl.alu_op = rv_pkg::ALU_SLL;
					{7'b0000000, 3'b010}: o_ctrl.alu_op = rv_pkg::ALU_SLT;
					{7'b0000000, 3'b100}: o_ctrl.alu_op = rv_pkg::ALU_XOR;
					{7'b0000000, 3'b101}: o_ctrl.alu_op = rv_pkg::ALU_SRL;
					{7'b0000000, 3'b110}: o_ctrl.alu_op = rv_pkg::ALU_OR;
					{7'b0000000, 3'b111}: o_ctrl.alu_op = rv_pkg::ALU_AND;
					default:              o_ctrl.reg_wen = 1'b0;
				endcase
			end
			rv_pkg::OPC_OP_IMM:
			begin
				use_rs1 = 1'b1;
				o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
				o_ctrl.use_imm = 1'b1;
				o_ctrl.reg_wen = 1'b1;
				case (funct3)
					3'b000:  o_ctrl.alu_op = rv_pkg::ALU_ADD;
					3'b010:  o_ctrl.alu_op = rv_pkg::ALU_SLT;
					3'b100:  o_ctrl.alu_op = rv_pkg::ALU_XOR;
					3'b110:  o_ctrl.alu_op = rv_pkg::ALU_OR;
					3'b111:  o_ctrl.alu_op = rv_pkg::ALU_AND;
					// Immediate shifts are not supported
					default: o_ctrl = '0;
				endcase
			end
			rv_pkg::OPC_LUI:
			begin
				o_imm = {i_inst[31:12], 12'b0};
				o_ctrl.alu_op  = rv_pkg::ALU_PASS_B;
				o_ctrl.use_imm = 1'b1;
				o_ctrl.reg_wen = 1'b1;
			end
			rv_pkg::OPC_LOAD:
			begin
				if (funct3 == 3'b010)
				begin
					use_rs1 = 1'b1;
					o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
					o_ctrl.use_imm     = 1'b1;
					o_ctrl.reg_wen     = 1'b1;
					o_ctrl.mem_read    = 1'b1;
					o_ctrl.wb_from_mem = 1'b1;
				end
			end
			rv_pkg::OPC_STORE:
			begin
				if (funct3 == 3'b010)
				begin
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
					o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
					o_ctrl.use_imm   = 1'b1;
					o_ctrl.mem_write = 1'b1;
				end
			end
			rv_pkg::OPC_BRANCH:
			begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
					i_inst[11:8], 1'b0};
				case (funct3)
					3'b000:  o_ctrl.branch_kind = rv_pkg::BR_BEQ;
					3'b001:  o_ctrl.branch_kind = rv_pkg::BR_BNE;
					3'b100:  o_ctrl.branch_kind = rv_pkg::BR_BLT;
					3'b101:  o_ctrl.branch_kind = rv_pkg::BR_BGE;
					default: o_ctrl.branch_kind = rv_pkg::BR_NONE;
				endcase
			end
			rv_pkg::OPC_JAL:
			begin
				o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
					i_inst[30:21], 1'b0};
				o_ctrl.reg_wen     = 1'b1;
				o_ctrl.branch_kind = rv_pkg::BR_JAL;
			end
			default:
				o_ctrl = '0;
		endcase
	end

endmodule

// File: logic/rv_hazard_unit.sv
// Forwarding and load-use detection
`timescale 1ns/100ps

module rv_hazard_unit (
	input  rv_pkg::reg_idx_t  i_rs1_ex,
	input  rv_pkg::reg_idx_t  i_rs2_ex,
	input  rv_pkg::reg_idx_t  i_rd_mem,
	input  logic              i_wen_mem,
	input  rv_pkg::reg_idx_t  i_rd_wb,
	input  logic              i_wen_wb,
	input  rv_pkg::reg_idx_t  i_rs1_id,
	input  rv_pkg::reg_idx_t  i_rs2_id,
	input  rv_pkg::reg_idx_t  i_rd_ex,
	input  logic              i_load_ex,
	output rv_pkg::opnd_sel_e o_sel_a,
	output rv_pkg::opnd_sel_e o_sel_b,
	output logic              o_load_stall
);

	// Youngest producer wins, so ex-mem is checked first
	function automatic rv_pkg::opnd_sel_e pick_src(
		rv_pkg::reg_idx_t rs,
		rv_pkg::reg_idx_t rd_mem,
		logic             wen_mem,
		rv_pkg::reg_idx_t rd_wb,
		logic             wen_wb
	);
		if (rs == '0)
			return rv_pkg::SEL_RF;
		else if (wen_mem && rd_mem == rs)
			return rv_pkg::SEL_MEM;
		else if (wen_wb && rd_wb == rs)
			return rv_pkg::SEL_WB;
		return rv_pkg::SEL_RF;
	endfunction

	assign o_sel_a = pick_src(i_rs1_ex, i_rd_mem, i_wen_mem, i_rd_wb, i_wen_wb);
	assign o_sel_b = pick_src(i_rs2_ex, i_rd_mem, i_wen_mem, i_rd_wb, i_wen_wb);

	// Load data is not ready for the next instruction in execute
	assign o_load_stall = i_load_ex && (i_rd_ex != '0)
		&& ((i_rd_ex == i_rs1_id) || (i_rd_ex == i_rs2_id));

endmodule

// File: logic/rv_pipe_reg.sv
// Pipeline stage register
`timescale 1ns/100ps

module rv_pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     i_hold,
	input  logic     i_flush,
	input  payload_t i_d,
	input  payload_t i_nop,
	output payload_t o_q
);

	// Hold has priority over flush
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_q <= i_nop;
		else if (!i_hold)
		begin
			if (i_flush)
				o_q <= i_nop;
			else
				o_q <= i_d;
		end
	end

endmodule

// File: logic/rv_pkg.sv
// RV32I pipeline definitions
package rv_pkg;

	// ==================================================
	// Widths and constants
	// ==================================================
	localparam int XLEN = 32;
	localparam int REG_COUNT = 32;
	localparam int SHAMT_W = $clog2(XLEN);

	typedef logic [XLEN-1:0] word_t;
	typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

	localparam word_t RESET_PC = 32'h0000_0000;
	// addi x0, x0, 0
	localparam word_t NOP_INST = 32'h0000_0013;

	// ==================================================
	// Encodings
	// ==================================================
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLT    = 4'd5,
		ALU_SLL    = 4'd6,
		ALU_SRL    = 4'd7,
		ALU_PASS_B = 4'd8
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BGE  = 3'd4,
		BR_JAL  = 3'd5
	} branch_kind_e;

	// Forwarding source of an execute operand
	typedef enum logic [1:0] {
		SEL_RF  = 2'd0,
		SEL_MEM = 2'd1,
		SEL_WB  = 2'd2
	} opnd_sel_e;

	// ==================================================
	// Control and stage payloads
	// ==================================================
	typedef struct packed {
		alu_op_e      alu_op;
		logic         use_imm;
		logic         reg_wen;
		logic         mem_read;
		logic         mem_write;
		logic         wb_from_mem;
		branch_kind_e branch_kind;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		word_t inst;
	} if_id_t;

	typedef struct packed {
		word_t    pc;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		word_t    rs1_val;
		word_t    rs2_val;
		word_t    imm;
		ctrl_t    ctrl;
	} id_ex_t;

	typedef struct packed {
		reg_idx_t rd;
		word_t    alu_out;
		word_t    store_data;
		logic     mem_read;
		logic     mem_write;
		logic     reg_wen;
		logic     wb_from_mem;
	} ex_mem_t;

	typedef struct packed {
		reg_idx_t rd;
		word_t    alu_out;
		word_t    mem_data;
		logic     reg_wen;
		logic     wb_from_mem;
	} mem_wb_t;

endpackage

// File: logic/rv_regfile.sv
// Integer register file
`timescale 1ns/100ps

module rv_regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  rv_pkg::reg_idx_t i_rs1,
	input  rv_pkg::reg_idx_t i_rs2,
	input  logic             i_wen,
	input  rv_pkg::reg_idx_t i_rd,
	input  rv_pkg::word_t    i_wdata,
	output rv_pkg::word_t    o_rs1_val,
	output rv_pkg::word_t    o_rs2_val
);

	// x0 has no storage
	rv_pkg::word_t regs [1:rv_pkg::REG_COUNT-1];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < rv_pkg::REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (i_wen && i_rd != '0)
			regs[i_rd] <= i_wdata;
	end

	// Same-cycle write is visible to decode
	function automatic rv_pkg::word_t read_port(rv_pkg::reg_idx_t idx);
		if (idx == '0)
			return '0;
		else if (i_wen && idx == i_rd)
			return i_wdata;
		return regs[idx];
	endfunction

	always_comb
	begin
		o_rs1_val = read_port(i_rs1);
		o_rs2_val = read_port(i_rs2);
	end

endmodule

// File: rv_core.f
logic/rv_pkg.sv
logic/rv_pipe_reg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_hazard_unit.sv
logic/rv_core.sv
tests/rv_core_tb.sv

// File: tests/rv_core_tb.sv
// RV32I core testbench
`timescale 1ns/100ps

module rv_core_tb;

	localparam int TIMEOUT_CYCLES = 3000;
	localparam int MODEL_STEPS = 2000;
	// jal x0, 0 spins in place and ends a program
	localparam rv_pkg::word_t END_MARK = 32'h0000_006f;

	logic             clk;
	logic             rst_n;
	logic             i_halt;
	rv_pkg::word_t    o_imem_addr;
	rv_pkg::word_t    i_imem_data;
	rv_pkg::word_t    o_dmem_addr;
	rv_pkg::word_t    o_dmem_wdata;
	logic             o_dmem_we;
	logic             o_dmem_re;
	rv_pkg::word_t    i_dmem_rdata;
	logic             o_wb_valid;
	rv_pkg::reg_idx_t o_wb_rd;
	rv_pkg::word_t    o_wb_data;

	rv_pkg::word_t    imem [256];
	rv_pkg::word_t    dmem [256];
	rv_pkg::word_t    prog [$];
	rv_pkg::reg_idx_t exp_rd [$];
	rv_pkg::word_t    exp_data [$];
	rv_pkg::word_t    exp_addr [$];
	rv_pkg::word_t    exp_wdata [$];

	int          wb_seen;
	int          st_seen;
	int          wb_total;
	int          st_total;
	int          errors;
	int          checks;
	int          tests;
	logic [31:0] rng;

	rv_core dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_halt       (i_halt),
		.o_imem_addr  (o_imem_addr),
		.i_imem_data  (i_imem_data),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.o_dmem_we    (o_dmem_we),
		.o_dmem_re    (o_dmem_re),
		.i_dmem_rdata (i_dmem_rdata),
		.o_wb_valid   (o_wb_valid),
		.o_wb_rd      (o_wb_rd),
		.o_wb_data    (o_wb_data)
	);

	always #10 clk = ~clk;

	// ==================================================
	// Memory models
	// ==================================================
	assign i_imem_data  = imem[o_imem_addr[9:2]];
	// Read data is only valid while o_dmem_re is high
	assign i_dmem_rdata = o_dmem_re ? dmem[o_dmem_addr[9:2]] : 'x;

	always @(posedge clk)
	begin
		if (o_dmem_we)
			dmem[o_dmem_addr[9:2]] <= o_dmem_wdata;
	end

	function automatic rv_pkg::word_t fill_word(int idx);
		return (32'h9E37_79B9 * (idx + 1)) ^ (idx << 16);
	endfunction

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// ==================================================
	// Instruction encoders
	// ==================================================
	function automatic rv_pkg::word_t enc_r(logic [6:0] f7, rv_pkg::reg_idx_t rs2,
		rv_pkg::reg_idx_t rs1, logic [2:0] f3, rv_pkg::reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic rv_pkg::word_t enc_i(logic [11:0] imm, rv_pkg::reg_idx_t rs1,
		logic [2:0] f3, rv_pkg::reg_idx_t rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv_pkg::word_t enc_s(logic [11:0] imm, rv_pkg::reg_idx_t rs2,
		rv_pkg::reg_idx_t rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic rv_pkg::word_t enc_b(logic [12:0] imm, rv_pkg::reg_idx_t rs2,
		rv_pkg::reg_idx_t rs1, logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic rv_pkg::word_t enc_u(logic [19:0] imm, rv_pkg::reg_idx_t rd);
		return {imm, rd, 7'h37};
	endfunction

	function automatic rv_pkg::word_t enc_j(logic [20:0] imm, rv_pkg::reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	function automatic rv_pkg::word_t random_alu(rv_pkg::reg_idx_t rd,
		rv_pkg::reg_idx_t rs1, rv_pkg::reg_idx_t rs2);
		logic [31:0] r;
		r = next_rand();
		case (r % 14)
			0:       return enc_r(7'h00, rs2, rs1, 3'd0, rd);
			1:       return enc_r(7'h20, rs2, rs1, 3'd0, rd);
			2:       return enc_r(7'h00, rs2, rs1, 3'd7, rd);
			3:       return enc_r(7'h00, rs2, rs1, 3'd6, rd);
			4:       return enc_r(7'h00, rs2, rs1, 3'd4, rd);
			5:       return enc_r(7'h00, rs2, rs1, 3'd2, rd);
			6:       return enc_r(7'h00, rs2, rs1, 3'd1, rd);
			7:       return enc_r(7'h00, rs2, rs1, 3'd5, rd);
			8:       return enc_i(r[27:16], rs1, 3'd0, rd, 7'h13);
			9:       return enc_i(r[27:16], rs1, 3'd7, rd, 7'h13);
			10:      return enc_i(r[27:16], rs1, 3'd6, rd, 7'h13);
			11:      return enc_i(r[27:16], rs1, 3'd4, rd, 7'h13);
			12:      return enc_i(r[27:16], rs1, 3'd2, rd, 7'h13);
			default: return enc_u(r[31:12], rd);
		endcase
	endfunction

	// ==================================================
	// Reference ISA model
	// ==================================================
	function automatic void model_program();
		rv_pkg::word_t    regs [32];
		rv_pkg::word_t    mem [256];
		rv_pkg::word_t    pc;
		rv_pkg::word_t    next_pc;
		rv_pkg::word_t    inst;
		rv_pkg::word_t    a;
		rv_pkg::word_t    b;
		rv_pkg::word_t    res;
		rv_pkg::word_t    addr;
		rv_pkg::word_t    imm_i;
		rv_pkg::word_t    imm_s;
		rv_pkg::word_t    imm_b;
		rv_pkg::word_t    imm_j;
		rv_pkg::reg_idx_t rd;
		logic [2:0]       f3;
		logic             wr;
		logic             take;
		int               steps;
		exp_rd.delete();
		exp_data.delete();
		exp_addr.delete();
		exp_wdata.delete();
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			mem[i] = fill_word(i);
		pc = rv_pkg::RESET_PC;
		steps = 0;
		while (imem[pc[9:2]] != END_MARK && steps < MODEL_STEPS)
		begin
			inst = imem[pc[9:2]];
			steps++;
			rd = inst[11:7];
			f3 = inst[14:12];
			a = regs[inst[19:15]];
			b = regs[inst[24:20]];
			imm_i = {{20{inst[31]}}, inst[31:20]};
			imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			next_pc = pc + 32'd4;
			wr = 1'b0;
			res = '0;
			case (inst[6:0])
				7'h33:
				begin
					wr = 1'b1;
					case (f3)
						3'd0: res = inst[30] ? a - b : a + b;
						3'd1: res = a << b[4:0];
						3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						3'd4: res = a ^ b;
						3'd5: res = a >> b[4:0];
						3'd6: res = a | b;
						default: res = a & b;
					endcase
				end
				7'h13:
				begin
					wr = 1'b1;
					case (f3)
						3'd0: res = a + imm_i;
						3'd2: res = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
						3'd4: res = a ^ imm_i;
						3'd6: res = a | imm_i;
						default: res = a & imm_i;
					endcase
				end
				7'h37:
				begin
					wr = 1'b1;
					res = {inst[31:12], 12'b0};
				end
				7'h03:
				begin
					wr = 1'b1;
					addr = a + imm_i;
					res = mem[addr[9:2]];
				end
				7'h23:
				begin
					addr = a + imm_s;
					mem[addr[9:2]] = b;
					exp_addr.push_back(addr);
					exp_wdata.push_back(b);
				end
				7'h63:
				begin
					case (f3)
						3'd0: take = (a == b);
						3'd1: take = (a != b);
						3'd4: take = ($signed(a) < $signed(b));
						default: take = ($signed(a) >= $signed(b));
					endcase
					if (take)
						next_pc = pc + imm_b;
				end
				default:
				begin
					// Only JAL remains in the generated programs
					wr = 1'b1;
					res = pc + 32'd4;
					next_pc = pc + imm_j;
				end
			endcase
			if (wr && rd != '0)
			begin
				regs[rd] = res;
				exp_rd.push_back(rd);
				exp_data.push_back(res);
			end
			pc = next_pc;
		end
	endfunction

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic check_wb(rv_pkg::reg_idx_t rd, rv_pkg::word_t data);
		rv_pkg::reg_idx_t exp_r;
		rv_pkg::word_t    exp_d;
		checks++;
		if (exp_rd.size() == 0)
		begin
			$display("Unexpected retirement of x%0d = 0x%08h at %0t", rd, data, $time);
			errors++;
		end
		else
		begin
			exp_r = exp_rd.pop_front();
			exp_d = exp_data.pop_front();
			if (rd !== exp_r || data !== exp_d)
			begin
				$display("** Error at %0t: retired x%0d = 0x%08h, expected x%0d = 0x%08h",
					$time, rd, data, exp_r, exp_d);
				errors++;
			end
		end
	endtask

	task automatic check_store(rv_pkg::word_t addr, rv_pkg::word_t data);
		rv_pkg::word_t exp_a;
		rv_pkg::word_t exp_d;
		checks++;
		if (exp_addr.size() == 0)
		begin
			$display("Unexpected store of 0x%08h to 0x%08h at %0t", data, addr, $time);
			errors++;
		end
		else
		begin
			exp_a = exp_addr.pop_front();
			exp_d = exp_wdata.pop_front();
			if (addr !== exp_a || data !== exp_d)
			begin
				$display("** Error at %0t: store 0x%08h to 0x%08h, expected 0x%08h to 0x%08h",
					$time, data, addr, exp_d, exp_a);
				errors++;
			end
		end
	endtask

	task automatic check_fetch(rv_pkg::word_t addr, rv_pkg::word_t expected);
		checks++;
		if (addr !== expected)
		begin
			$display("** Error at %0t: fetch address 0x%08h, expected 0x%08h",
				$time, addr, expected);
			errors++;
		end
	endtask

	task automatic check_low(logic value, string what);
		checks++;
		if (value !== 1'b0)
		begin
			$display("** Error at %0t: %s is not low", $time, what);
			errors++;
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (rst_n === 1'b1)
		begin
			if (i_halt)
			begin
				check_low(o_wb_valid, "o_wb_valid during halt");
				check_low(o_dmem_we, "o_dmem_we during halt");
				check_low(o_dmem_re, "o_dmem_re during halt");
			end
			if (o_wb_valid)
			begin
				check_wb(o_wb_rd, o_wb_data);
				wb_seen++;
			end
			if (o_dmem_we)
			begin
				check_store(o_dmem_addr, o_dmem_wdata);
				st_seen++;
			end
		end
	end

	// ==================================================
	// Program generators
	// ==================================================
	task automatic build_alu_program();
		logic [31:0]      r;
		rv_pkg::reg_idx_t rd;
		rv_pkg::reg_idx_t prev;
		rv_pkg::reg_idx_t prev2;
		prog.delete();
		r = next_rand();
		prog.push_back(enc_u(r[31:12], 5'd1));
		prog.push_back(enc_i(r[11:0], 5'd1, 3'd0, 5'd1, 7'h13));
		prog.push_back(enc_u(r[19:0], 5'd2));
		prev = 5'd1;
		prev2 = 5'd2;
		// Each result feeds the next and the one before comes from write-back
		for (int i = 0; i < 30; i++)
		begin
			r = next_rand();
			rd = 5'd1 + r[2:0] % 7;
			prog.push_back(random_alu(rd, prev, prev2));
			prev2 = prev;
			prev = rd;
		end
	endtask

	task automatic build_mem_program();
		logic [31:0] r;
		logic [31:0] v;
		prog.delete();
		prog.push_back(enc_i(12'd256, 5'd0, 3'd0, 5'd5, 7'h13));
		for (int i = 0; i < 8; i++)
		begin
			r = next_rand();
			v = next_rand();
			prog.push_back(enc_u(v[31:12], 5'd6));
			prog.push_back(enc_i(v[11:0], 5'd6, 3'd0, 5'd6, 7'h13));
			prog.push_back(enc_s({3'b0, r[6:0], 2'b0}, 5'd6, 5'd5));
			prog.push_back(enc_i({3'b0, r[6:0], 2'b0}, 5'd5, 3'd2, 5'd7, 7'h03));
			prog.push_back(enc_r(7'h00, 5'd6, 5'd7, 3'd0, 5'd8));
			prog.push_back(enc_s({3'b0, r[13:7], 2'b0}, 5'd8, 5'd5));
			prog.push_back(enc_i({3'b0, r[20:14], 2'b0}, 5'd5, 3'd2, 5'd9, 7'h03));
			prog.push_back(enc_s({3'b0, r[27:21], 2'b0}, 5'd9, 5'd5));
			prog.push_back(enc_r(7'h00, 5'd8, 5'd9, 3'd4, 5'd10));
		end
	endtask

	task automatic build_branch_program();
		logic [2:0]  kinds [4];
		logic [31:0] r;
		logic [11:0] v;
		logic [11:0] n;
		logic [11:0] a;
		logic [11:0] b;
		kinds = '{3'd0, 3'd1, 3'd4, 3'd5};
		prog.delete();
		for (int k = 0; k < 4; k++)
		begin
			// Equal, less and greater operand pairs
			for (int p = 0; p < 3; p++)
			begin
				r = next_rand();
				v = {1'b0, r[10:0]};
				n = ~v;
				a = (p == 1) ? n : v;
				b = (p == 2) ? n : v;
				prog.push_back(enc_i(a, 5'd0, 3'd0, 5'd1, 7'h13));
				prog.push_back(enc_i(b, 5'd0, 3'd0, 5'd2, 7'h13));
				prog.push_back(enc_b(13'd12, 5'd2, 5'd1, kinds[k]));
				prog.push_back(enc_i(r[27:16], 5'd0, 3'd0, 5'd3, 7'h13));
				prog.push_back(enc_s(12'd16, 5'd3, 5'd0));
				prog.push_back(enc_i(12'd1, 5'd4, 3'd0, 5'd4, 7'h13));
			end
		end
		prog.push_back(enc_j(21'd12, 5'd1));
		prog.push_back(enc_i(12'd7, 5'd0, 3'd0, 5'd3, 7'h13));
		prog.push_back(enc_s(12'd20, 5'd3, 5'd0));
		prog.push_back(enc_r(7'h00, 5'd1, 5'd4, 3'd0, 5'd4));
	endtask

	task automatic build_mixed_program();
		logic [31:0]      r;
		rv_pkg::reg_idx_t rd;
		rv_pkg::reg_idx_t prev;
		prog.delete();
		prog.push_back(enc_i(12'd256, 5'd0, 3'd0, 5'd5, 7'h13));
		prev = 5'd1;
		for (int i = 0; i < 40; i++)
		begin
			r = next_rand();
			rd = 5'd1 + r[1:0];
			case (r[31:30])
				2'd0: prog.push_back(enc_s({3'b0, r[8:2], 2'b0}, prev, 5'd5));
				2'd1: prog.push_back(enc_i({3'b0, r[8:2], 2'b0}, 5'd5, 3'd2, rd, 7'h03));
				default: prog.push_back(random_alu(rd, prev, 5'd1 + r[5:4]));
			endcase
			if (r[31:30] != 2'd0)
				prev = rd;
		end
	endtask

	// ==================================================
	// Sequencing
	// ==================================================
	task automatic apply_reset(bit check_reset);
		@(posedge clk);
		rst_n <= 1'b0;
		i_halt <= 1'b0;
		for (int c = 0; c < 10; c++)
		begin
			@(negedge clk);
			if (c == 0)
			begin
				for (int i = 0; i < 256; i++)
				begin
					imem[i] = (i < prog.size()) ? prog[i] : END_MARK;
					dmem[i] = fill_word(i);
				end
				model_program();
				wb_total = exp_rd.size();
				st_total = exp_addr.size();
				wb_seen = 0;
				st_seen = 0;
			end
			if (check_reset)
			begin
				check_fetch(o_imem_addr, rv_pkg::RESET_PC);
				check_low(o_dmem_we, "o_dmem_we in reset");
				check_low(o_dmem_re, "o_dmem_re in reset");
				check_low(o_wb_valid, "o_wb_valid in reset");
			end
			@(posedge clk);
		end
		rst_n <= 1'b1;
	endtask

	task automatic wait_done(string name, bit use_halt);
		int          cycles;
		logic [31:0] r;
		cycles = 0;
		while ((wb_seen < wb_total || st_seen < st_total) && cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			if (use_halt)
			begin
				r = next_rand();
				i_halt <= (r[1:0] == 2'b00);
			end
			cycles++;
		end
		@(posedge clk);
		i_halt <= 1'b0;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: test %s stalled with %0d of %0d writes and %0d of %0d stores",
				name, wb_seen, wb_total, st_seen, st_total);
			errors++;
		end
		// Drain so that a stray wrong-path result still shows up
		for (int c = 0; c < 12; c++)
			@(posedge clk);
	endtask

	task automatic run_test(string name, bit use_halt, bit check_reset);
		int errs_before;
		errs_before = errors;
		apply_reset(check_reset);
		if (check_reset)
		begin
			// First instruction reaches write-back in the fifth cycle
			for (int c = 0; c < 4; c++)
			begin
				@(negedge clk);
				if (c == 0)
					check_fetch(o_imem_addr, rv_pkg::RESET_PC);
				check_low(o_dmem_we, "o_dmem_we after reset");
				check_low(o_dmem_re, "o_dmem_re after reset");
				check_low(o_wb_valid, "o_wb_valid after reset");
			end
		end
		wait_done(name, use_halt);
		tests++;
		$display("Test %0d %s finished: %0d writes, %0d stores, %0d errors",
			tests, name, wb_seen, st_seen, errors - errs_before);
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		i_halt = 1'b0;
		rng = 32'd55301;
		errors = 0;
		checks = 0;
		tests = 0;
		wb_seen = 0;
		st_seen = 0;
		wb_total = 0;
		st_total = 0;
		for (int i = 0; i < 256; i++)
		begin
			imem[i] = END_MARK;
			dmem[i] = fill_word(i);
		end

		build_alu_program();
		run_test("alu_chain", 1'b0, 1'b0);
		build_mem_program();
		run_test("store_load", 1'b0, 1'b0);
		build_branch_program();
		run_test("branch_jal", 1'b0, 1'b0);
		build_mixed_program();
		run_test("random_halt", 1'b1, 1'b0);
		prog.delete();
		prog.push_back(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
		prog.push_back(enc_s(12'd0, 5'd1, 5'd0));
		prog.push_back(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
		run_test("reset_state", 1'b0, 1'b1);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
